//--- console_macros.svh
// default tick counts and widths for the console glue logic
`ifndef CONSOLE_MACROS_SVH
`define CONSOLE_MACROS_SVH

// gClk runs at about 8.388 MHz
`define SECOND_TICKS    8388608     // gClk cycles per second
`define DEBOUNCE_TICKS  65536       // stable cycles before a button is taken
`define TICK_BITS       24          // covers one full second

// esp32 power-up delay
`define ESP_STEP_TICKS  4096        // cycles per delay step
`define ESP_STEPS       8           // delay steps before enable

// cartridge detect filter
`define CART_WINDOW     18          // shift history length
`define CART_EDGE_LO    2           // lowest bit of the edge compare
`define CART_PRESENT_LO 3           // presence decode window
`define CART_PRESENT_HI 6

// pads and status led
`define PAD_BITS        9           // eight buttons plus menu
`define DIM_BITS        5           // yellow dimming counter

`endif

//--- boardIoPkg.sv
// board pin types: pad buttons, status flags, rgb led and esp32 control pins
package boardIoPkg;

    // start sits at bit 0, same layout as the mcu button vector
    typedef struct packed {
        logic menu;     // bit 8
        logic down;
        logic left;
        logic right;
        logic up;
        logic a;
        logic b;
        logic select;
        logic start;    // bit 0
    } padState_t;

    // status flags from the system monitor, white wins
    typedef struct packed {
        logic white;
        logic green;
        logic yellow;
        logic red;
    } ledStatus_t;

    // led pins are active low
    typedef struct packed {
        logic red;
        logic green;
        logic blue;
    } ledRgb_t;

    typedef struct packed {
        logic enable;   // esp32 chip enable
        logic io0;      // boot strap pin
    } espPins_t;

endpackage

//--- timingPkg.sv
// tick counter, dimming counter and shift window vector types
`include "console_macros.svh"

package timingPkg;

    // cycle counter, wide enough for a second of gClk
    typedef logic [`TICK_BITS-1:0] tickCount_t;

    // cartridge detect history, bit 0 is newest
    typedef logic [`CART_WINDOW-1:0] cartWindow_t;

    typedef logic [`DIM_BITS-1:0] dimCount_t;   // led dimming

    // esp32 enable delay
    typedef logic [$clog2(`ESP_STEP_TICKS)-1:0] espStep_t;
    typedef logic [`ESP_STEPS-1:0] espShift_t;

endpackage

//--- timebase.sv
// timebase module: second, half-second and hundredth-second enable pulses
`timescale 1ns/10ps
`include "console_macros.svh"

module timebase #(
    parameter int secondTicks = `SECOND_TICKS
) (
    input  logic gClk,
    input  logic lock_o,
    output logic secondEna_o,
    output logic halfSecondEna_o,
    output logic percentEna_o
);
    import timingPkg::*;

    localparam tickCount_t secondLast  = tickCount_t'(secondTicks - 1);
    localparam tickCount_t halfLast    = tickCount_t'(secondTicks / 2 - 1);
    localparam tickCount_t percentLast = tickCount_t'(secondTicks / 100 - 1);

    tickCount_t secondCnt;
    tickCount_t percentCnt;

    always_ff @(posedge gClk or negedge lock_o) begin
        if (!lock_o) begin
            secondCnt       <= '0;
            percentCnt      <= '0;
            secondEna_o     <= 1'b0;
            halfSecondEna_o <= 1'b0;
            percentEna_o    <= 1'b0;
        end else begin
            percentEna_o <= 1'b0;
            if (percentCnt == percentLast) begin
                percentEna_o <= 1'b1;
                percentCnt   <= '0;
            end else begin
                percentCnt <= percentCnt + 1'b1;
            end

            secondEna_o     <= 1'b0;
            halfSecondEna_o <= (secondCnt == halfLast);     // mid-second pulse
            if (secondCnt == secondLast) begin
                secondEna_o     <= 1'b1;
                halfSecondEna_o <= 1'b1;
                secondCnt       <= '0;
                percentCnt      <= '0;      // keep hundredths aligned to the second
            end else begin
                secondCnt <= secondCnt + 1'b1;
            end
        end
    end

endmodule

//--- cartMonitor.sv
// cartMonitor module: cartridge detect filter, memory reset pulse, presence flag
`timescale 1ns/10ps
`include "console_macros.svh"

module cartMonitor (
    input  logic gClk,
    input  logic lock_o,
    input  logic cartDet_i,
    output logic memReset_o,
    output logic cartPresent_o
);
    import timingPkg::*;

    localparam int edgeBits = `CART_WINDOW - `CART_EDGE_LO;

    // one old level at the top, the new level held below it
    localparam logic [edgeBits-1:0] insertPat = {1'b0, {(edgeBits - 1){1'b1}}};
    localparam logic [edgeBits-1:0] removePat = ~insertPat;

    cartWindow_t         detWindow;
    logic [edgeBits-1:0] edgeView;

    assign edgeView = detWindow[`CART_WINDOW-1:`CART_EDGE_LO];

    always_ff @(posedge gClk or negedge lock_o) begin
        if (!lock_o) begin
            detWindow  <= '0;
            memReset_o <= 1'b1;     // memories held while the pll is unlocked
        end else begin
            detWindow  <= {detWindow[`CART_WINDOW-2:0], cartDet_i};
            memReset_o <= (edgeView == insertPat) || (edgeView == removePat);
        end
    end

    // near end of the window, settles a few cycles after insertion
    assign cartPresent_o = &detWindow[`CART_PRESENT_HI:`CART_PRESENT_LO];

endmodule

//--- padInput.sv
// padInput module: button debounce, remote button merge and menu request gating
`timescale 1ns/10ps
`include "console_macros.svh"

module padInput #(
    parameter int debounceTicks = `DEBOUNCE_TICKS
) (
    input  logic                  gClk,
    input  logic                  lock_o,
    input  boardIoPkg::padState_t rawPad_i,
    input  boardIoPkg::padState_t remotePad_i,
    input  logic                  cartPresent_i,
    input  logic                  menuReady_i,
    output boardIoPkg::padState_t pad_o,
    output logic                  menuRequest_o
);
    import boardIoPkg::*;
    import timingPkg::*;

    localparam tickCount_t stableLast = tickCount_t'(debounceTicks - 1);

    padState_t            physPad;
    logic [`PAD_BITS-1:0] physBits;
    logic [`PAD_BITS-1:0] heldBits;

    // menu button is wired active low on the board
    always_comb begin
        physPad      = rawPad_i;
        physPad.menu = ~rawPad_i.menu;
    end

    assign physBits = physPad;

    for (genvar i = 0; i < `PAD_BITS; i++) begin : g_button
        logic       lastLvl;
        logic       held;
        tickCount_t stableCnt;

        always_ff @(posedge gClk or negedge lock_o) begin
            if (!lock_o) begin
                lastLvl   <= 1'b0;
                held      <= 1'b0;
                stableCnt <= '0;
            end else if (physBits[i] != lastLvl) begin
                lastLvl   <= physBits[i];   // bounce restarts the count
                stableCnt <= '0;
            end else if (stableCnt == stableLast) begin
                held <= lastLvl;
            end else begin
                stableCnt <= stableCnt + 1'b1;
            end
        end

        assign heldBits[i] = held;
    end

    always_ff @(posedge gClk or negedge lock_o) begin
        if (!lock_o) begin
            pad_o <= '0;
        end else begin
            pad_o <= padState_t'(heldBits | remotePad_i);   // mcu can press too
        end
    end

    // menu only reaches the system once a cartridge is in and the menu is up
    assign menuRequest_o = pad_o.menu & cartPresent_i & menuReady_i;

endmodule

//--- ledDriver.sv
// ledDriver module: status flag priority to active-low rgb led with yellow dimming
`timescale 1ns/10ps
`include "console_macros.svh"

module ledDriver (
    input  logic                   gClk,
    input  logic                   lock_o,
    input  boardIoPkg::ledStatus_t ledStatus_i,
    output boardIoPkg::ledRgb_t    ledRgb_o
);
    import boardIoPkg::*;
    import timingPkg::*;

    localparam ledRgb_t rgbOff = '{red: 1'b1, green: 1'b1, blue: 1'b1};

    dimCount_t dimCnt;

    always_ff @(posedge gClk or negedge lock_o) begin
        if (!lock_o) begin
            dimCnt   <= '0;
            ledRgb_o <= rgbOff;
        end else begin
            dimCnt <= dimCnt + 1'b1;
            if (ledStatus_i.white) begin
                ledRgb_o <= '{red: 1'b0, green: 1'b0, blue: 1'b0};
            end else if (ledStatus_i.green) begin
                ledRgb_o <= '{red: 1'b1, green: 1'b0, blue: 1'b1};
            end else if (ledStatus_i.yellow) begin
                // red plus half-duty green
                ledRgb_o <= '{red: 1'b0, green: dimCnt[`DIM_BITS-1], blue: 1'b1};
            end else if (ledStatus_i.red) begin
                ledRgb_o <= '{red: 1'b0, green: 1'b1, blue: 1'b1};
            end else begin
                ledRgb_o <= rgbOff;
            end
        end
    end

endmodule

//--- startupSequencer.sv
// startupSequencer module: usb reset hold and esp32 enable and boot pin sequencing
`timescale 1ns/10ps
`include "console_macros.svh"

module startupSequencer (
    input  logic                 gClk,
    input  logic                 lock_o,
    input  logic                 secondEna_i,
    input  logic                 uartDtr_i,
    input  logic                 uartRts_i,
    output logic                 usbReset_o,
    output boardIoPkg::espPins_t esp_o
);
    import timingPkg::*;

    localparam espStep_t stepLast = espStep_t'(`ESP_STEP_TICKS - 1);

    logic      espReq;
    logic      stepTick;
    espStep_t  stepCnt;
    espShift_t enableDelay;

    // usb core stays in reset for the first second after lock
    always_ff @(posedge gClk or negedge lock_o) begin
        if (!lock_o) begin
            usbReset_o <= 1'b1;
        end else if (secondEna_i) begin
            usbReset_o <= 1'b0;
        end
    end

    assign stepTick = (stepCnt == stepLast);

    always_ff @(posedge gClk or negedge lock_o) begin
        if (!lock_o) begin
            stepCnt <= '0;
        end else if (stepTick) begin
            stepCnt <= '0;
        end else begin
            stepCnt <= stepCnt + 1'b1;
        end
    end

    always_ff @(posedge gClk or negedge lock_o) begin
        if (!lock_o) begin
            espReq      <= 1'b0;
            enableDelay <= '0;
            esp_o       <= '{enable: 1'b0, io0: 1'b1};
        end else begin
            espReq    <= ~uartRts_i;                // host rts low asks for run
            esp_o.io0 <= ~uartDtr_i & ~uartRts_i;   // boot strap from dtr/rts

            if (!espReq) begin
                enableDelay  <= '0;         // drop at once
                esp_o.enable <= 1'b0;
            end else begin
                if (stepTick) begin
                    enableDelay <= {enableDelay[`ESP_STEPS-2:0], 1'b1};
                end
                esp_o.enable <= enableDelay[`ESP_STEPS-1];
            end
        end
    end

endmodule

//--- consoleGlue.sv
// consoleGlue top: timebase, cartridge monitor, pad input, led driver and startup
`timescale 1ns/10ps
`include "console_macros.svh"

module consoleGlue #(
    parameter int secondTicks   = `SECOND_TICKS,
    parameter int debounceTicks = `DEBOUNCE_TICKS
) (
    input  logic                   gClk,
    input  logic                   lock_o,
    input  boardIoPkg::padState_t  rawPad_i,       // menu active low
    input  boardIoPkg::padState_t  remotePad_i,
    input  logic                   cartDet_i,
    input  logic                   menuReady_i,
    input  boardIoPkg::ledStatus_t ledStatus_i,
    input  logic                   uartDtr_i,
    input  logic                   uartRts_i,
    output boardIoPkg::padState_t  pad_o,
    output logic                   menuRequest_o,
    output logic                   memReset_o,
    output logic                   cartPresent_o,
    output boardIoPkg::ledRgb_t    ledRgb_o,
    output boardIoPkg::espPins_t   esp_o,
    output logic                   usbReset_o,
    output logic                   secondEna_o,
    output logic                   halfSecondEna_o,
    output logic                   percentEna_o
);

    logic secondEna;
    logic cartPresent;

    assign secondEna_o   = secondEna;
    assign cartPresent_o = cartPresent;

    timebase #(
        .secondTicks(secondTicks)
    ) u_timebase (
        .gClk           (gClk),
        .lock_o         (lock_o),
        .secondEna_o    (secondEna),
        .halfSecondEna_o(halfSecondEna_o),
        .percentEna_o   (percentEna_o)
    );

    cartMonitor u_cartMonitor (
        .gClk         (gClk),
        .lock_o       (lock_o),
        .cartDet_i    (cartDet_i),
        .memReset_o   (memReset_o),
        .cartPresent_o(cartPresent)
    );

    padInput #(
        .debounceTicks(debounceTicks)
    ) u_padInput (
        .gClk         (gClk),
        .lock_o       (lock_o),
        .rawPad_i     (rawPad_i),
        .remotePad_i  (remotePad_i),
        .cartPresent_i(cartPresent),
        .menuReady_i  (menuReady_i),
        .pad_o        (pad_o),
        .menuRequest_o(menuRequest_o)
    );

    ledDriver u_ledDriver (
        .gClk       (gClk),
        .lock_o     (lock_o),
        .ledStatus_i(ledStatus_i),
        .ledRgb_o   (ledRgb_o)
    );

    startupSequencer u_startupSequencer (
        .gClk       (gClk),
        .lock_o     (lock_o),
        .secondEna_i(secondEna),
        .uartDtr_i  (uartDtr_i),
        .uartRts_i  (uartRts_i),
        .usbReset_o (usbReset_o),
        .esp_o      (esp_o)
    );

endmodule

//--- tb_consoleGlue.sv
// tb_consoleGlue testbench: clock, reset, data file commands, check tasks and result line
`timescale 1ns/10ps
`include "console_macros.svh"

module tb_consoleGlue;
    import boardIoPkg::*;

    logic       gClk;
    logic       lock_o;
    padState_t  rawPad;
    padState_t  remotePad;
    logic       cartDet;
    logic       menuReady;
    ledStatus_t ledStatus;
    logic       uartDtr;
    logic       uartRts;
    padState_t  pad;
    logic       menuRequest;
    logic       memReset;
    logic       cartPresent;
    ledRgb_t    ledRgb;
    espPins_t   esp;
    logic       usbReset;
    logic       secondEna;
    logic       halfSecondEna;
    logic       percentEna;

    int     valueErrors;
    int     timeoutErrors;
    integer seed;
    logic   prevRts;

    consoleGlue #(
        .secondTicks  (200),
        .debounceTicks(4)
    ) u_dut (
        .gClk           (gClk),
        .lock_o         (lock_o),
        .rawPad_i       (rawPad),
        .remotePad_i    (remotePad),
        .cartDet_i      (cartDet),
        .menuReady_i    (menuReady),
        .ledStatus_i    (ledStatus),
        .uartDtr_i      (uartDtr),
        .uartRts_i      (uartRts),
        .pad_o          (pad),
        .menuRequest_o  (menuRequest),
        .memReset_o     (memReset),
        .cartPresent_o  (cartPresent),
        .ledRgb_o       (ledRgb),
        .esp_o          (esp),
        .usbReset_o     (usbReset),
        .secondEna_o    (secondEna),
        .halfSecondEna_o(halfSecondEna),
        .percentEna_o   (percentEna)
    );

    initial begin
        gClk = 1'b0;
        forever #4 gClk = ~gClk;    // 8 ns period
    end

    // sample just after the edge
    task automatic waitCycles(input int n);
        repeat (n) @(posedge gClk);
        #1;
    endtask

    task automatic checkPad(input string name, input padState_t expVal, input padState_t actVal);
        if (actVal !== expVal) begin
            $display("Error at %0t: %s expected %h got %h", $time, name, expVal, actVal);
            valueErrors++;
        end
    endtask

    task automatic checkRgb(input string name, input ledRgb_t expVal, input ledRgb_t actVal);
        if (actVal !== expVal) begin
            $display("Error at %0t: %s expected %b got %b", $time, name, expVal, actVal);
            valueErrors++;
        end
    endtask

    task automatic checkEsp(input string name, input espPins_t expVal, input espPins_t actVal);
        if (actVal !== expVal) begin
            $display("Error at %0t: %s expected %b got %b", $time, name, expVal, actVal);
            valueErrors++;
        end
    endtask

    task automatic checkBit(input string name, input logic expVal, input logic actVal);
        if (actVal !== expVal) begin
            $display("Error at %0t: %s expected %b got %b", $time, name, expVal, actVal);
            valueErrors++;
        end
    endtask

    // pulse counts within a tolerance for window phase
    task automatic checkCount(input string name, input int expVal, input int actVal,
                              input int tol);
        if (actVal > expVal + tol || actVal < expVal - tol) begin
            $display("Error at %0t: %s expected %0d got %0d", $time, name, expVal, actVal);
            valueErrors++;
        end
    endtask

    task automatic countTimebasePulses();
        int cnt;
        int secCnt;
        int halfCnt;
        int pctCnt;
        cnt = 0;
        while (usbReset && cnt < 210) begin
            waitCycles(1);
            cnt++;
        end
        if (usbReset) begin
            $display("Timeout: usbReset_o still high 210 cycles after lock");
            timeoutErrors++;
        end
        secCnt = 0;
        halfCnt = 0;
        pctCnt = 0;
        for (int i = 0; i < 1000; i++) begin
            waitCycles(1);
            secCnt += int'(secondEna);
            halfCnt += int'(halfSecondEna);
            pctCnt += int'(percentEna);
        end
        checkCount("secondEna_o pulses", 5, secCnt, 1);
        checkCount("halfSecondEna_o pulses", 10, halfCnt, 1);
        checkCount("percentEna_o pulses", 500, pctCnt, 1);
    endtask

    task automatic settlePad(input logic [31:0] raw, input logic [31:0] remote,
                             input logic [31:0] cart, input logic [31:0] ready,
                             input logic [31:0] expPad, input logic [31:0] expMenu);
        logic [31:0] bounce;
        @(posedge gClk);
        remotePad <= remote[8:0];
        cartDet   <= cart[0];
        menuReady <= ready[0];
        repeat (12) begin
            @(posedge gClk);
            bounce = $random(seed);
            rawPad <= bounce[8:0];      // contact bounce
        end
        @(posedge gClk);
        rawPad <= raw[8:0];
        waitCycles(20);
        checkPad("pad_o", expPad[8:0], pad);
        checkBit("menuRequest_o", expMenu[0], menuRequest);
    endtask

    // glitch of width cycles watched past where a leading edge pulse would be
    task automatic watchCartEdge(input logic level, input int width, input int expPulses);
        int pulses;
        int presentAt;
        int watch;
        pulses = 0;
        presentAt = -1;
        watch = (width > 0) ? width + 14 : 30;
        @(posedge gClk);
        cartDet <= level;
        for (int i = 1; i <= watch; i++) begin
            @(posedge gClk);
            if (width > 0 && i == width) begin
                cartDet <= ~level;
            end
            #1;
            pulses += int'(memReset);
            if (presentAt < 0 && cartPresent == level) begin
                presentAt = i;
            end
        end
        checkCount("memReset_o pulses", expPulses, pulses, 0);
        if (width == 0 && (presentAt < 0 || presentAt > 10)) begin
            $display("Timeout: cartPresent_o did not follow cartDet_i within 10 cycles");
            timeoutErrors++;
        end
        if (width > 0) begin
            waitCycles(20);     // return edge is a clean change of its own
        end
    endtask

    task automatic showLedStatus(input logic [31:0] status, input logic [31:0] expRgb);
        ledStatus_t st;
        ledRgb_t    expVal;
        logic       seenHi;
        logic       seenLo;
        st = status[3:0];
        expVal = expRgb[2:0];
        @(posedge gClk);
        ledStatus <= st;
        waitCycles(2);
        if (st.yellow && !st.white && !st.green) begin
            checkBit("ledRgb_o.red", expVal.red, ledRgb.red);
            checkBit("ledRgb_o.blue", expVal.blue, ledRgb.blue);
            seenHi = 1'b0;
            seenLo = 1'b0;
            for (int i = 0; i < 64; i++) begin
                waitCycles(1);
                seenHi |= ledRgb.green;
                seenLo |= ~ledRgb.green;
            end
            if (!(seenHi && seenLo)) begin
                $display("Yellow dimming missing: ledRgb_o.green never toggled in 64 cycles");
                valueErrors++;
            end
        end else begin
            checkRgb("ledRgb_o", expVal, ledRgb);
        end
    endtask

    task automatic sequenceEsp(input logic [31:0] dtr, input logic [31:0] rts,
                               input logic [31:0] expPins);
        int cnt;
        @(posedge gClk);
        uartDtr <= dtr[0];
        uartRts <= rts[0];
        waitCycles(2);
        checkEsp("esp_o", expPins[1:0], esp);
        if (!rts[0] && prevRts) begin
            cnt = 2;
            while (!esp.enable && cnt < 8 * `ESP_STEP_TICKS + 10) begin
                waitCycles(1);
                cnt++;
            end
            if (!esp.enable) begin
                $display("Timeout: esp_o.enable did not rise after uartRts_i went low");
                timeoutErrors++;
            end else if (cnt < 7 * `ESP_STEP_TICKS) begin
                $display("esp_o.enable rose too early, %0d cycles after uartRts_i fell", cnt);
                valueErrors++;
            end
        end
        prevRts = rts[0];
    endtask

    initial begin
        int          fd;
        int          code;
        string       cmd;
        logic [8*120-1:0] lineBuf;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [31:0] e;
        logic [31:0] f;
        seed = 78638;
        valueErrors = 0;
        timeoutErrors = 0;
        prevRts = 1'b1;
        lock_o = 1'b0;
        rawPad = 9'h100;        // menu released
        remotePad = '0;
        cartDet = 1'b0;
        menuReady = 1'b0;
        ledStatus = '0;
        uartDtr = 1'b1;
        uartRts = 1'b1;
        repeat (3) @(posedge gClk);
        lock_o <= 1'b1;
        #1;
        // no edge since release, outputs still hold their reset values
        checkBit("memReset_o", 1'b1, memReset);
        checkBit("usbReset_o", 1'b1, usbReset);
        checkPad("pad_o", '0, pad);
        checkBit("menuRequest_o", 1'b0, menuRequest);
        checkRgb("ledRgb_o", 3'b111, ledRgb);
        checkEsp("esp_o", 2'b01, esp);
        fd = $fopen("stimulus_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open stimulus_input.txt");
            timeoutErrors++;
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%s", cmd);
                if (code != 1) break;
                if (cmd == "#") begin
                    code = $fgets(lineBuf, fd);
                end else if (cmd == "usb") begin
                    countTimebasePulses();
                end else if (cmd == "pad") begin
                    code = $fscanf(fd, "%h %h %h %h %h %h", a, b, c, d, e, f);
                    settlePad(a, b, c, d, e, f);
                end else if (cmd == "led") begin
                    code = $fscanf(fd, "%h %h", a, b);
                    showLedStatus(a, b);
                end else if (cmd == "cart") begin
                    code = $fscanf(fd, "%h %h", a, b);
                    watchCartEdge(a[0], 0, int'(b));
                end else if (cmd == "glitch") begin
                    code = $fscanf(fd, "%h %h", a, b);
                    watchCartEdge(a[0], int'(b), 0);
                end else if (cmd == "esp") begin
                    code = $fscanf(fd, "%h %h %h", a, b, c);
                    sequenceEsp(a, b, c);
                end else begin
                    $display("Unknown command %s in stimulus_input.txt", cmd);
                    valueErrors++;
                end
            end
            $fclose(fd);
        end
        $display("value errors: %0d, timeout errors: %0d", valueErrors, timeoutErrors);
        if (valueErrors == 0 && timeoutErrors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- stimulus_input.txt
# all values hex: usb | pad raw remote cart ready expPad expMenu | led status expRgb
# cart level expPulse | glitch level width | esp dtr rts expPins(enable,io0)
usb
pad 100 000 1 1 000 0
pad 105 020 1 1 025 0
pad 000 000 1 1 100 1
pad 000 000 1 0 100 0
pad 100 100 1 1 100 1
pad 1ff 000 1 1 0ff 0
pad 000 003 0 1 103 0
cart 1 1
cart 0 1
glitch 1 a
cart 1 1
glitch 0 a
led 0 7
led 8 0
led 1 3
led 4 5
led 2 1
led 3 1
led 6 5
led f 0
esp 1 1 0
esp 1 0 0
esp 0 0 3
esp 0 1 0
esp 0 0 1

//--- project.f
+incdir+.
boardIoPkg.sv
timingPkg.sv
timebase.sv
cartMonitor.sv
padInput.sv
ledDriver.sv
startupSequencer.sv
consoleGlue.sv
tb_consoleGlue.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the console glue testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f project.f --top-module tb_consoleGlue -o simv \
    && ./obj_dir/simv > sim.log 2>&1 \
    || { echo "build or run failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -qx "ALL CHECKS PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
